// ==== mmix_dec_pkg.sv ====
////////////////////////////////////////////////////////////
// common definitions for the mmix dispatch decoder
// bus widths, operand spec record, internal opcodes and the
// per-opcode tables; decoder modules import this package
////////////////////////////////////////////////////////////

package mmix_dec_pkg;

	localparam int inst_w     = 32;
	localparam int addr_w     = 64;
	localparam int reg_w      = 8;	// register number, G and L
	localparam int ring_ptr_w = 62;	// width of O

	localparam int lring_mask = 255;	// local ring holds 256 registers

	// bit positions inside a flag_table entry
	localparam int flag_z_imm      = 0;	// Z is an immediate
	localparam int flag_z_reg      = 1;	// $Z is a source
	localparam int flag_y_imm      = 2;	// Y is an immediate
	localparam int flag_y_reg      = 3;	// $Y is a source
	localparam int flag_x_src      = 4;	// $X is a source
	localparam int flag_x_dest     = 5;	// $X is written
	localparam int flag_rel_addr   = 6;	// YZ or XYZ is a relative address
	localparam int flag_ctl_change = 7;	// fetch may be redirected here

	localparam logic [7:0] op_jmp     = 8'hf0;
	localparam logic [7:0] op_trap    = 8'h00;
	localparam logic [7:0] op_trip    = 8'hff;
	localparam logic [3:0] wyde_group = 4'he;	// SET/INC/OR/ANDN with wyde immediates

	typedef enum logic [1:0] {
		spec_none   = 2'd0,
		spec_global = 2'd1,	// g[addr]
		spec_local  = 2'd2	// l[addr], already wrapped on the ring
	} spec_kind_t;

	typedef struct packed {
		logic [addr_w-1:0] value;	// meaningful only when known
		logic              known;
		spec_kind_t        kind;
		logic [reg_w-1:0]  addr;
	} spec_t;

	localparam spec_t no_spec = '{value: '0, known: 1'b0, kind: spec_none, addr: '0};

	typedef enum logic [7:0] {
		noop, trap, trip,
		add, addu, sub, subu, cmp, cmpu,
		shl, shlu, shr, shru,
		br, ld, st, pst,
		or_, orn, nor_, xor_, and_, andn, nand_, nxor,
		set, jmp, pushj, put, pop, unsave, get
	} iop_t;

	// unsupported slots hold trap, the classifier overrides them anyway
	localparam iop_t iop_table [0:255] = '{
		trap, trap, trap, trap, trap, trap, trap, trap,	// 0x00
		trap, trap, trap, trap, trap, trap, trap, trap,
		trap, trap, trap, trap, trap, trap, trap, trap,
		trap, trap, trap, trap, trap, trap, trap, trap,
		add, add, addu, addu, sub, sub, subu, subu,	// 0x20
		trap, trap, trap, trap, trap, trap, trap, trap,
		cmp, cmp, cmpu, cmpu, sub, sub, subu, subu,	// NEG shares sub
		shl, shl, shlu, shlu, shr, shr, shru, shru,
		br, br, br, br, br, br, br, br,	// 0x40
		br, br, br, br, br, br, br, br,
		trap, trap, trap, trap, trap, trap, trap, trap,	// PB group
		trap, trap, trap, trap, trap, trap, trap, trap,
		trap, trap, trap, trap, trap, trap, trap, trap,	// CS/ZS group
		trap, trap, trap, trap, trap, trap, trap, trap,
		trap, trap, trap, trap, trap, trap, trap, trap,
		trap, trap, trap, trap, trap, trap, trap, trap,
		ld, ld, ld, ld, ld, ld, ld, ld,	// 0x80
		ld, ld, ld, ld, ld, ld, ld, ld,
		trap, trap, trap, trap, trap, trap, trap, trap,
		trap, trap, trap, trap, trap, trap, trap, trap,
		pst, pst, pst, pst, pst, pst, pst, pst,	// 0xa0, partial stores
		pst, pst, pst, pst, st, st, st, st,
		trap, trap, trap, trap, st, st, trap, trap,	// only STCO
		trap, trap, trap, trap, trap, trap, trap, trap,
		or_, or_, orn, orn, nor_, nor_, xor_, xor_,	// 0xc0
		and_, and_, andn, andn, nand_, nand_, nxor, nxor,
		trap, trap, trap, trap, trap, trap, trap, trap,
		trap, trap, trap, trap, trap, trap, trap, trap,
		set, set, set, set, addu, addu, addu, trap,	// 0xe0, INCL left out
		trap, trap, trap, trap, trap, trap, trap, trap,
		jmp, jmp, pushj, pushj, trap, trap, put, put,	// 0xf0
		pop, trap, trap, unsave, trap, trap, get, trip
	};

	// branches carry the control-change bit, they are predicted taken
	localparam logic [7:0] flag_table [0:255] = '{
		8'h8a, 8'h2a, 8'h2a, 8'h2a, 8'h2a, 8'h26, 8'h2a, 8'h26,	// TRAP row
		8'h26, 8'h25, 8'h26, 8'h25, 8'h26, 8'h25, 8'h26, 8'h25,
		8'h2a, 8'h2a, 8'h2a, 8'h2a, 8'h2a, 8'h26, 8'h2a, 8'h26,
		8'h2a, 8'h29, 8'h2a, 8'h29, 8'h2a, 8'h29, 8'h2a, 8'h29,
		8'h2a, 8'h29, 8'h2a, 8'h29, 8'h2a, 8'h29, 8'h2a, 8'h29,	// ADD row
		8'h2a, 8'h29, 8'h2a, 8'h29, 8'h2a, 8'h29, 8'h2a, 8'h29,
		8'h2a, 8'h29, 8'h2a, 8'h29, 8'h26, 8'h25, 8'h26, 8'h25,	// NEG has Y imm
		8'h2a, 8'h29, 8'h2a, 8'h29, 8'h2a, 8'h29, 8'h2a, 8'h29,
		8'hd0, 8'hd0, 8'hd0, 8'hd0, 8'hd0, 8'hd0, 8'hd0, 8'hd0,	// Bcc
		8'hd0, 8'hd0, 8'hd0, 8'hd0, 8'hd0, 8'hd0, 8'hd0, 8'hd0,
		8'h50, 8'h50, 8'h50, 8'h50, 8'h50, 8'h50, 8'h50, 8'h50,
		8'h50, 8'h50, 8'h50, 8'h50, 8'h50, 8'h50, 8'h50, 8'h50,
		8'h3a, 8'h39, 8'h3a, 8'h39, 8'h3a, 8'h39, 8'h3a, 8'h39,
		8'h3a, 8'h39, 8'h3a, 8'h39, 8'h3a, 8'h39, 8'h3a, 8'h39,
		8'h2a, 8'h29, 8'h2a, 8'h29, 8'h2a, 8'h29, 8'h2a, 8'h29,
		8'h2a, 8'h29, 8'h2a, 8'h29, 8'h2a, 8'h29, 8'h2a, 8'h29,
		8'h2a, 8'h29, 8'h2a, 8'h29, 8'h2a, 8'h29, 8'h2a, 8'h29,	// loads
		8'h2a, 8'h29, 8'h2a, 8'h29, 8'h2a, 8'h29, 8'h2a, 8'h29,
		8'h2a, 8'h29, 8'h2a, 8'h29, 8'h3a, 8'h39, 8'h2a, 8'h29,
		8'h2a, 8'h29, 8'h0a, 8'h09, 8'h0a, 8'h09, 8'haa, 8'ha9,
		8'h1a, 8'h19, 8'h1a, 8'h19, 8'h1a, 8'h19, 8'h1a, 8'h19,	// stores read $X
		8'h1a, 8'h19, 8'h1a, 8'h19, 8'h1a, 8'h19, 8'h1a, 8'h19,
		8'h1a, 8'h19, 8'h1a, 8'h19, 8'h0a, 8'h09, 8'h1a, 8'h19,
		8'h0a, 8'h09, 8'h0a, 8'h09, 8'h0a, 8'h09, 8'haa, 8'ha9,
		8'h2a, 8'h29, 8'h2a, 8'h29, 8'h2a, 8'h29, 8'h2a, 8'h29,	// logic ops
		8'h2a, 8'h29, 8'h2a, 8'h29, 8'h2a, 8'h29, 8'h2a, 8'h29,
		8'h2a, 8'h29, 8'h2a, 8'h29, 8'h2a, 8'h29, 8'h2a, 8'h29,
		8'h2a, 8'h29, 8'h2a, 8'h29, 8'h2a, 8'h29, 8'h2a, 8'h29,
		8'h20, 8'h20, 8'h20, 8'h20, 8'h30, 8'h30, 8'h30, 8'h30,	// SET/INC
		8'h30, 8'h30, 8'h30, 8'h30, 8'h30, 8'h30, 8'h30, 8'h30,
		8'hc0, 8'hc0, 8'he0, 8'he0, 8'h60, 8'h60, 8'h02, 8'h01,	// JMP row
		8'h80, 8'h80, 8'h00, 8'h02, 8'h01, 8'h00, 8'h20, 8'h8a
	};

	// index 0 is the msb, one byte per row of eight opcodes
	localparam logic [0:255] support_table = {
		8'b1000_0000, 8'b0000_0000, 8'b0000_0000, 8'b0000_0000,	// 0x00
		8'b1111_1111, 8'b0000_0000, 8'b1111_1111, 8'b1111_1111,	// 0x20
		8'b1111_1111, 8'b1111_1111, 8'b0000_0000, 8'b0000_0000,	// 0x40
		8'b0000_0000, 8'b0000_0000, 8'b0000_0000, 8'b0000_0000,	// 0x60
		8'b1111_1111, 8'b1111_1111, 8'b0000_0000, 8'b0000_0000,	// 0x80
		8'b1111_1111, 8'b1111_1111, 8'b0000_1100, 8'b0000_0000,	// 0xa0
		8'b1111_1111, 8'b1111_1111, 8'b0000_0000, 8'b0000_0000,	// 0xc0
		8'b1111_1110, 8'b0000_0000, 8'b1111_0011, 8'b1001_0011	// 0xe0
	};

	// known immediate operand
	function automatic spec_t imm_spec(input logic [addr_w-1:0] value);
		spec_t s;
		s       = no_spec;
		s.value = value;
		s.known = 1'b1;
		return s;
	endfunction

	// register number to g[] or to its slot on the local ring
	function automatic spec_t reg_spec(
		input logic [reg_w-1:0]      num,
		input logic [reg_w-1:0]      g_top,
		input logic [ring_ptr_w-1:0] o_base
	);
		spec_t                 s;
		logic [ring_ptr_w-1:0] ring;
		s      = no_spec;
		ring   = (o_base + ring_ptr_w'(num)) & ring_ptr_w'(lring_mask);
		s.kind = spec_local;
		s.addr = ring[reg_w-1:0];
		if (num >= g_top) begin
			s.kind = spec_global;
			s.addr = num;
		end
		return s;
	endfunction

	// between L and G, neither local nor global
	function automatic logic is_marginal(
		input logic [reg_w-1:0] num,
		input logic [reg_w-1:0] g_top,
		input logic [reg_w-1:0] l_size
	);
		return (num >= l_size) && (num < g_top);
	endfunction

endpackage

// ==== opcode_classifier.sv ====
////////////////////////////////////////////////////////////
// classifies the opcode of one instruction
// applies the support and TRIP gating, then splits the
// flag byte into the controls both decoders use
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module opcode_classifier (
	input  logic [mmix_dec_pkg::inst_w-1:0] inst,
	input  logic [mmix_dec_pkg::addr_w-1:0] loc,
	output mmix_dec_pkg::iop_t              iop,
	output logic                            y_imm,
	output logic                            y_reg,
	output logic                            z_imm,
	output logic                            z_reg,
	output logic                            x_src,
	output logic                            x_dest,
	output logic                            rel_addr,
	output logic                            ctl_flag
);

	import mmix_dec_pkg::*;

	logic [7:0] op;
	logic [7:0] flags;	// selected flag_table entry

	assign op = inst[inst_w-1:inst_w-8];

	always_comb begin
		if (!support_table[op]) begin
			// anything not implemented traps, with TRAP operands
			iop   = trap;
			flags = flag_table[op_trap];
		end else if ((op == op_trip) && loc[addr_w-1]) begin
			iop   = noop;	// TRIP in negative (kernel) space does nothing
			flags = 8'h00;
		end else begin
			iop   = iop_table[op];
			flags = flag_table[op];
		end
	end

	assign z_imm    = flags[flag_z_imm];
	assign z_reg    = flags[flag_z_reg];
	assign y_imm    = flags[flag_y_imm];
	assign y_reg    = flags[flag_y_reg];
	assign x_src    = flags[flag_x_src];
	assign x_dest   = flags[flag_x_dest];
	assign rel_addr = flags[flag_rel_addr];
	assign ctl_flag = flags[flag_ctl_change];	// qualified by iop in dispatch

endmodule

// ==== operand_decoder.sv ====
////////////////////////////////////////////////////////////
// builds the Y and Z operand specs of one instruction
// relative targets, wyde immediates, plain immediates and
// register operands mapped to g[] or the local ring
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module operand_decoder (
	input  logic [mmix_dec_pkg::inst_w-1:0]     inst,
	input  logic [mmix_dec_pkg::addr_w-1:0]     loc,
	input  logic [mmix_dec_pkg::reg_w-1:0]      g_top,
	input  logic [mmix_dec_pkg::reg_w-1:0]      l_size,
	input  logic [mmix_dec_pkg::ring_ptr_w-1:0] o_base,
	input  mmix_dec_pkg::iop_t                  iop,
	input  logic                                y_imm,
	input  logic                                y_reg,
	input  logic                                z_imm,
	input  logic                                z_reg,
	input  logic                                rel_addr,
	output mmix_dec_pkg::spec_t                 y_spec,
	output mmix_dec_pkg::spec_t                 z_spec
);

	import mmix_dec_pkg::*;

	logic [7:0]        op;
	logic [7:0]        xx;
	logic [7:0]        yy;
	logic [7:0]        zz;
	logic [15:0]       yz;
	logic              wyde;	// SET/INC/OR/ANDN style instruction
	logic [5:0]        wyde_shift;
	logic [addr_w-1:0] rel_disp;	// byte displacement, already signed

	assign {op, xx, yy, zz} = inst;
	assign yz = inst[15:0];

	// a trapped E-group opcode keeps the TRAP operand pattern
	assign wyde = (op[7:4] == wyde_group) && (iop != trap);

	// opcode bits 1:0 pick H, MH, ML, L -> 48, 32, 16, 0
	assign wyde_shift = {~op[1:0], 4'b0000};

	// op[0] is the backward bit, it fills the upper bits so the
	// field reads as field - 2^24 (or 2^16) words
	always_comb begin
		if (op[7:1] == op_jmp[7:1])
			rel_disp = {{38{op[0]}}, inst[23:0], 2'b00};	// JMP uses XYZ
		else
			rel_disp = {{46{op[0]}}, yz, 2'b00};	// branches, PUSHJ use YZ
	end

	always_comb begin
		y_spec = no_spec;
		z_spec = no_spec;
		if (rel_addr) begin
			y_spec = imm_spec(loc + addr_w'(4));	// return / fall-through address
			z_spec = imm_spec(loc + rel_disp);	// target
		end else begin
			if (wyde)
				z_spec = imm_spec(addr_w'(yz) << wyde_shift);
			else if (z_imm)
				z_spec = imm_spec(addr_w'(zz));
			else if (z_reg)
				z_spec = reg_spec(zz, g_top, o_base);

			if (wyde && (iop != set)) begin
				// INC/OR/ANDN read $X as the Y operand
				// a marginal $X has no live copy to read
				if (!is_marginal(xx, g_top, l_size))
					y_spec = reg_spec(xx, g_top, o_base);
			end else if (y_imm) begin
				y_spec = imm_spec(addr_w'(yy));
			end else if (y_reg) begin
				y_spec = reg_spec(yy, g_top, o_base);
			end
		end
	end

endmodule

// ==== register_target_decoder.sv ====
////////////////////////////////////////////////////////////
// renames the X destination and decodes $X as source B
// global above G, ring slot below L, marginal gets nothing
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module register_target_decoder (
	input  logic [mmix_dec_pkg::inst_w-1:0]     inst,
	input  logic [mmix_dec_pkg::reg_w-1:0]      g_top,
	input  logic [mmix_dec_pkg::reg_w-1:0]      l_size,
	input  logic [mmix_dec_pkg::ring_ptr_w-1:0] o_base,
	input  logic                                x_src,
	input  logic                                x_dest,
	output mmix_dec_pkg::spec_t                 x_spec,
	output logic                                ren_x,
	output mmix_dec_pkg::spec_t                 b_spec
);

	import mmix_dec_pkg::*;

	logic [reg_w-1:0] xx;
	logic             x_marginal;
	spec_t            x_map;	// $X as g[] or l[] address

	assign xx = inst[23:16];

	assign x_marginal = is_marginal(xx, g_top, l_size);
	assign x_map      = reg_spec(xx, g_top, o_base);

	// destination rename
	// the stack is not grown here, so a marginal X stays unrenamed
	always_comb begin
		x_spec = no_spec;
		ren_x  = 1'b0;
		if (x_dest && !x_marginal) begin
			x_spec = x_map;
			ren_x  = 1'b1;
		end
	end

	// stores and branches read $X through B
	always_comb begin
		if (x_src && !x_marginal)
			b_spec = x_map;
		else
			b_spec = no_spec;	// not a source, or marginal
	end

endmodule

// ==== dispatch_stage.sv ====
////////////////////////////////////////////////////////////
// output register of the decoder
// captures the decoded record on each strobe and raises
// the fetch redirect for jumps, branches and PUSHJ
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module dispatch_stage (
	input  logic                            clk,
	input  logic                            arst_n,
	input  logic                            inst_valid,
	input  mmix_dec_pkg::iop_t              iop,
	input  logic                            ctl_flag,
	input  mmix_dec_pkg::spec_t             y_spec,
	input  mmix_dec_pkg::spec_t             z_spec,
	input  mmix_dec_pkg::spec_t             x_spec,
	input  logic                            ren_x,
	input  mmix_dec_pkg::spec_t             b_spec,
	output logic                            dec_valid,
	output mmix_dec_pkg::iop_t              dec_iop,
	output mmix_dec_pkg::spec_t             dec_x,
	output logic                            dec_ren_x,
	output mmix_dec_pkg::spec_t             dec_b,
	output mmix_dec_pkg::spec_t             dec_y,
	output mmix_dec_pkg::spec_t             dec_z,
	output logic                            ctl_change,
	output logic [mmix_dec_pkg::addr_w-1:0] inst_ptr
);

	import mmix_dec_pkg::*;

	logic redirect;	// this instruction moves the fetch point

	// flag alone is not enough, TRAP and POP also carry it
	assign redirect = ctl_flag && (iop inside {jmp, br, pushj});

	// strobe-qualified control, cleared by reset
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			dec_valid  <= 1'b0;
			ctl_change <= 1'b0;
		end else begin
			dec_valid  <= inst_valid;
			ctl_change <= inst_valid && redirect;
		end
	end

	// record fields, held between strobes
	always_ff @(posedge clk) begin
		if (inst_valid) begin
			dec_iop   <= iop;
			dec_x     <= x_spec;
			dec_ren_x <= ren_x;
			dec_b     <= b_spec;
			dec_y     <= y_spec;
			dec_z     <= z_spec;
			inst_ptr  <= redirect ? z_spec.value : '0;	// target sits in Z
		end
	end

endmodule

// ==== inst_decoder.sv ====
////////////////////////////////////////////////////////////
// mmix dispatch decoder, top level
// one instruction per strobe, decoded record one cycle later
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module inst_decoder (
	input  logic                                clk,
	input  logic                                arst_n,
	input  logic                                inst_valid,	// one-cycle strobe
	input  logic [mmix_dec_pkg::inst_w-1:0]     inst,
	input  logic [mmix_dec_pkg::addr_w-1:0]     loc,
	input  logic [mmix_dec_pkg::reg_w-1:0]      g_top,	// G
	input  logic [mmix_dec_pkg::reg_w-1:0]      l_size,	// L
	input  logic [mmix_dec_pkg::ring_ptr_w-1:0] o_base,	// O
	output logic                                dec_valid,
	output mmix_dec_pkg::iop_t                  dec_iop,
	output mmix_dec_pkg::spec_t                 dec_x,
	output logic                                dec_ren_x,
	output mmix_dec_pkg::spec_t                 dec_b,
	output mmix_dec_pkg::spec_t                 dec_y,
	output mmix_dec_pkg::spec_t                 dec_z,
	output logic                                ctl_change,
	output logic [mmix_dec_pkg::addr_w-1:0]     inst_ptr
);

	import mmix_dec_pkg::*;

	iop_t  iop;
	logic  y_imm, y_reg, z_imm, z_reg;
	logic  x_src, x_dest, rel_addr, ctl_flag;
	spec_t y_spec, z_spec;
	spec_t x_spec, b_spec;
	logic  ren_x;

	opcode_classifier u_classifier (
		.inst     (inst),
		.loc      (loc),
		.iop      (iop),
		.y_imm    (y_imm),
		.y_reg    (y_reg),
		.z_imm    (z_imm),
		.z_reg    (z_reg),
		.x_src    (x_src),
		.x_dest   (x_dest),
		.rel_addr (rel_addr),
		.ctl_flag (ctl_flag)
	);

	operand_decoder u_operands (
		.inst     (inst),
		.loc      (loc),
		.g_top    (g_top),
		.l_size   (l_size),
		.o_base   (o_base),
		.iop      (iop),
		.y_imm    (y_imm),
		.y_reg    (y_reg),
		.z_imm    (z_imm),
		.z_reg    (z_reg),
		.rel_addr (rel_addr),
		.y_spec   (y_spec),
		.z_spec   (z_spec)
	);

	register_target_decoder u_target (
		.inst   (inst),
		.g_top  (g_top),
		.l_size (l_size),
		.o_base (o_base),
		.x_src  (x_src),
		.x_dest (x_dest),
		.x_spec (x_spec),
		.ren_x  (ren_x),
		.b_spec (b_spec)
	);

	// the only sequential stage
	dispatch_stage u_dispatch (
		.clk        (clk),
		.arst_n     (arst_n),
		.inst_valid (inst_valid),
		.iop        (iop),
		.ctl_flag   (ctl_flag),
		.y_spec     (y_spec),
		.z_spec     (z_spec),
		.x_spec     (x_spec),
		.ren_x      (ren_x),
		.b_spec     (b_spec),
		.dec_valid  (dec_valid),
		.dec_iop    (dec_iop),
		.dec_x      (dec_x),
		.dec_ren_x  (dec_ren_x),
		.dec_b      (dec_b),
		.dec_y      (dec_y),
		.dec_z      (dec_z),
		.ctl_change (ctl_change),
		.inst_ptr   (inst_ptr)
	);

endmodule

// ==== tb_inst_decoder.sv ====
////////////////////////////////////////////////////////////
// testbench for the mmix dispatch decoder
// random instructions, locations and G/L/O groups from a
// fixed seed, checked one cycle later against a local model
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module tb_inst_decoder;

	import mmix_dec_pkg::*;

	localparam int reset_cycles = 5;
	localparam int group_len    = 100;	// cycles per G/L/O setting
	localparam int n_groups     = 8;
	localparam int n_cycles     = group_len * n_groups;
	localparam int cycle_limit  = n_cycles * 2 + reset_cycles + 20;

	// one expected decoded record
	typedef struct packed {
		iop_t              iop;
		spec_t             x;
		logic              ren_x;
		spec_t             b;
		spec_t             y;
		spec_t             z;
		logic              ctl;
		logic [addr_w-1:0] ptr;
	} rec_t;

	logic                  clk;
	logic                  arst_n;
	logic                  inst_valid;
	logic [inst_w-1:0]     inst;
	logic [addr_w-1:0]     loc;
	logic [reg_w-1:0]      g_top;
	logic [reg_w-1:0]      l_size;
	logic [ring_ptr_w-1:0] o_base;
	logic                  dec_valid;
	iop_t                  dec_iop;
	spec_t                 dec_x;
	logic                  dec_ren_x;
	spec_t                 dec_b;
	spec_t                 dec_y;
	spec_t                 dec_z;
	logic                  ctl_change;
	logic [addr_w-1:0]     inst_ptr;

	integer seed;
	int     cycles;
	rec_t   exp_q[$];	// one entry per strobe in strobe order

	inst_decoder u_dut (
		.clk        (clk),
		.arst_n     (arst_n),
		.inst_valid (inst_valid),
		.inst       (inst),
		.loc        (loc),
		.g_top      (g_top),
		.l_size     (l_size),
		.o_base     (o_base),
		.dec_valid  (dec_valid),
		.dec_iop    (dec_iop),
		.dec_x      (dec_x),
		.dec_ren_x  (dec_ren_x),
		.dec_b      (dec_b),
		.dec_y      (dec_y),
		.dec_z      (dec_z),
		.ctl_change (ctl_change),
		.inst_ptr   (inst_ptr)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;	// 20 ns period
	end

	// hard stop if the stimulus loop ever stalls
	initial begin
		cycles = 0;
		forever begin
			@(posedge clk);
			cycles = cycles + 1;
			if (cycles > cycle_limit) begin
				$display("timeout: stimulus did not finish within %0d cycles", cycle_limit);
				$display("Test FAILED");
				$fatal(1, "run stopped by the cycle limit");
			end
		end
	end

	function automatic logic [31:0] rand32();
		return $random(seed);
	endfunction

	task automatic check_value(input logic [127:0] got, input logic [127:0] exp,
		input string what);
		if (got !== exp) begin
			$display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
			$display("Test FAILED");
			$fatal(1, "mismatch on %s", what);
		end
	endtask

	function automatic spec_t known_val(input logic [addr_w-1:0] v);
		spec_t s;
		s       = '0;
		s.value = v;
		s.known = 1'b1;
		return s;
	endfunction

	// global at or above G and a slot on the local ring below it
	function automatic spec_t map_reg(input logic [7:0] num, input logic [7:0] g,
		input logic [ring_ptr_w-1:0] o);
		spec_t                 s;
		logic [ring_ptr_w-1:0] ring;
		s    = '0;
		ring = (o + {54'd0, num}) & ring_ptr_w'(lring_mask);
		if (num >= g) begin
			s.kind = spec_global;
			s.addr = num;
		end else begin
			s.kind = spec_local;
			s.addr = ring[7:0];
		end
		return s;
	endfunction

	function automatic logic marginal(input logic [7:0] num, input logic [7:0] g,
		input logic [7:0] l);
		return (num >= l) && (num < g);	// between L and G
	endfunction

	// reference decode of one instruction
	function automatic rec_t expect_record(input logic [31:0] in, input logic [63:0] at,
		input logic [7:0] g, input logic [7:0] l, input logic [ring_ptr_w-1:0] o);
		rec_t        r;
		logic [7:0]  op;
		logic [7:0]  xx;
		logic [7:0]  yy;
		logic [7:0]  zz;
		logic [15:0] yz;
		logic [7:0]  fl;
		logic        wyde;
		logic [63:0] off;	// word offset
		int          shift;
		r  = '0;
		op = in[31:24];
		xx = in[23:16];
		yy = in[15:8];
		zz = in[7:0];
		yz = in[15:0];
		if (!support_table[op]) begin
			r.iop = trap;
			fl    = flag_table[op_trap];
		end else if ((op == op_trip) && at[63]) begin
			r.iop = noop;
			fl    = 8'h00;
		end else begin
			r.iop = iop_table[op];
			fl    = flag_table[op];
		end
		wyde  = (op[7:4] == wyde_group) && (r.iop != trap);
		shift = 48 - 16 * int'(op[1:0]);	// H, MH, ML, L
		if (fl[flag_rel_addr]) begin
			if (op[7:1] == op_jmp[7:1]) begin
				off = {40'd0, in[23:0]};
				if (op[0])
					off = off - 64'h0000_0000_0100_0000;	// backward jump
			end else begin
				off = {48'd0, yz};
				if (op[0])
					off = off - 64'h0000_0000_0001_0000;
			end
			r.y = known_val(at + 64'd4);
			r.z = known_val(at + (off << 2));
		end else begin
			if (wyde)
				r.z = known_val({48'd0, yz} << shift);
			else if (fl[flag_z_imm])
				r.z = known_val({56'd0, zz});
			else if (fl[flag_z_reg])
				r.z = map_reg(zz, g, o);
			if (wyde && (r.iop != set)) begin
				if (!marginal(xx, g, l))
					r.y = map_reg(xx, g, o);	// INC/OR/ANDN read $X
			end else if (fl[flag_y_imm]) begin
				r.y = known_val({56'd0, yy});
			end else if (fl[flag_y_reg]) begin
				r.y = map_reg(yy, g, o);
			end
		end
		if (fl[flag_x_dest] && !marginal(xx, g, l)) begin
			r.x     = map_reg(xx, g, o);
			r.ren_x = 1'b1;
		end
		if (fl[flag_x_src] && !marginal(xx, g, l))
			r.b = map_reg(xx, g, o);
		r.ctl = fl[flag_ctl_change] && ((r.iop == jmp) || (r.iop == br) || (r.iop == pushj));
		if (r.ctl)
			r.ptr = r.z.value;
		return r;
	endfunction

	// biased so traps, TRIP, jumps, branches and wydes all show up
	function automatic logic [7:0] pick_opcode();
		logic [31:0] r;
		r = rand32();
		case (r[2:0])
			3'd0:    return 8'hff;	// TRIP
			3'd1:    return {7'h78, r[8]};	// JMP or JMPB
			3'd2:    return {4'h4, r[11:8]};	// Bcc, both directions
			3'd3:    return {5'b11100, r[10:8]};
			default: return r[15:8];
		endcase
	endfunction

	task automatic check_outputs(input logic cap_valid, input rec_t e, input logic have_last);
		check_value(128'(dec_valid), 128'(cap_valid), "dec_valid");
		check_value(128'(ctl_change), 128'(cap_valid && e.ctl), "ctl_change");
		if (have_last) begin	// fields hold between strobes
			check_value(128'(dec_iop), 128'(e.iop), "dec_iop");
			check_value(128'(dec_x), 128'(e.x), "dec_x");
			check_value(128'(dec_ren_x), 128'(e.ren_x), "dec_ren_x");
			check_value(128'(dec_b), 128'(e.b), "dec_b");
			check_value(128'(dec_y), 128'(e.y), "dec_y");
			check_value(128'(dec_z), 128'(e.z), "dec_z");
			check_value(128'(inst_ptr), 128'(e.ptr), "inst_ptr");
		end
	endtask

	initial begin
		logic [31:0]           r;
		logic [31:0]           r2;
		logic                  cap_valid;
		logic                  have_last;
		logic                  new_valid;
		logic [31:0]           new_inst;
		logic [63:0]           new_loc;
		logic [7:0]            new_g;
		logic [7:0]            new_l;
		logic [ring_ptr_w-1:0] new_o;
		rec_t                  last;
		seed       = 37;
		have_last  = 1'b0;
		new_g      = 8'd0;
		new_l      = 8'd0;
		new_o      = '0;
		arst_n     = 1'b0;
		inst_valid = 1'b0;
		inst       = '0;
		loc        = '0;
		g_top      = '0;
		l_size     = '0;
		o_base     = '0;
		repeat (reset_cycles) @(posedge clk);
		arst_n <= 1'b1;

		for (int i = 0; i < n_cycles; i++) begin
			@(posedge clk);
			cap_valid = inst_valid;	// what the DUT takes on this edge
			if (i % group_len == 0) begin
				r     = rand32();
				new_g = r[7:0];
				r     = rand32();
				new_l = 8'(r % (32'(new_g) + 32'd1));	// L never above G
				r     = rand32();
				r2    = rand32();
				new_o = {r[29:0], r2};
			end
			r         = rand32();
			new_valid = (i >= 3) && (r[1:0] != 2'b00);	// quiet start and then about 3 of 4
			new_inst  = {pick_opcode(), r[31:8]};
			r         = rand32();
			r2        = rand32();
			new_loc   = {r, r2[31:2], 2'b00};
			new_loc[63] = r2[0];	// both kernel and user space
			if (new_valid)
				exp_q.push_back(expect_record(new_inst, new_loc, new_g, new_l, new_o));
			inst_valid <= new_valid;
			inst       <= new_inst;
			loc        <= new_loc;
			g_top      <= new_g;
			l_size     <= new_l;
			o_base     <= new_o;
			@(negedge clk);
			if (cap_valid) begin
				last      = exp_q.pop_front();
				have_last = 1'b1;
			end
			check_outputs(cap_valid, last, have_last);
		end

		// drain the last strobe
		@(posedge clk);
		cap_valid = inst_valid;
		inst_valid <= 1'b0;
		@(negedge clk);
		if (cap_valid) begin
			last      = exp_q.pop_front();
			have_last = 1'b1;
		end
		check_outputs(cap_valid, last, have_last);

		$display("Test OK");
		$finish;
	end

endmodule

// ==== flist.f ====
mmix_dec_pkg.sv
opcode_classifier.sv
operand_decoder.sv
register_target_decoder.sv
dispatch_stage.sv
inst_decoder.sv
tb_inst_decoder.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     = --binary --timing -j 0
TOP       = tb_inst_decoder
FLIST     = flist.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "Test OK" $(LOG) || (echo "simulation failed"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
